// File: rv_core.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_core_tb.sv

// File: rv_core_tb_prog.svh
// columns: insn, load data, pc, addr, store data, write enable, halt
task automatic load_program();
  word_t lw_data;
  lw_data = 32'h8a7f_c3e1;
  add_row(32'h0000_000f, 0, 0, 0, 0, 4'h0, 0);
  add_row(32'hffff_ffff, 0, 4, 0, 0, 4'h0, 0);
  add_row(enc_u(20'h12345, 1, op_lui), 0, 8, 0, 0, 4'h0, 0);
  add_row(enc_s(16, 1, 0, f3_word), 0, 12, 16, 32'h1234_5000, 4'hf, 0);
  add_row(enc_u(20'h00001, 2, op_auipc), 0, 16, 0, 0, 4'h0, 0);
  add_row(enc_s(20, 2, 0, f3_word), 0, 20, 20, 32'h0000_1010, 4'hf, 0);
  add_row(enc_i(-5, 0, f3_add, 3, op_reg_imm), 0, 24, 0, 0, 4'h0, 0);
  add_row(enc_i(7, 0, f3_add, 4, op_reg_imm), 0, 28, 0, 0, 4'h0, 0);
  add_row(enc_r(f7_base, 4, 3, f3_add, 5), 0, 32, 0, 0, 4'h0, 0);
  add_row(enc_s(0, 5, 0, f3_word), 0, 36, 0, 32'h0000_0002, 4'hf, 0);
  add_row(enc_r(f7_alt, 3, 4, f3_add, 6), 0, 40, 0, 0, 4'h0, 0);
  add_row(enc_s(4, 6, 0, f3_word), 0, 44, 4, 32'h0000_000c, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 3, f3_xor, 7), 0, 48, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 7, 0, f3_word), 0, 52, 8, 32'hffff_fffc, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 3, f3_or, 8), 0, 56, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 8, 0, f3_word), 0, 60, 8, 32'hffff_ffff, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 3, f3_and, 9), 0, 64, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 9, 0, f3_word), 0, 68, 8, 32'h0000_0003, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 4, f3_sll, 10), 0, 72, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 10, 0, f3_word), 0, 76, 8, 32'h0000_0380, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 3, f3_srl, 11), 0, 80, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 11, 0, f3_word), 0, 84, 8, 32'h01ff_ffff, 4'hf, 0);
  add_row(enc_r(f7_alt, 4, 3, f3_srl, 12), 0, 88, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 12, 0, f3_word), 0, 92, 8, 32'hffff_ffff, 4'hf, 0);
  add_row(enc_i(12'd28, 4, f3_sll, 13, op_reg_imm), 0, 96, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 13, 0, f3_word), 0, 100, 8, 32'h7000_0000, 4'hf, 0);
  add_row(enc_i(12'd28, 3, f3_srl, 14, op_reg_imm), 0, 104, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 14, 0, f3_word), 0, 108, 8, 32'h0000_000f, 4'hf, 0);
  add_row(enc_i(12'h401, 3, f3_srl, 15, op_reg_imm), 0, 112, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 15, 0, f3_word), 0, 116, 8, 32'hffff_fffd, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 3, f3_slt, 16), 0, 120, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 16, 0, f3_word), 0, 124, 8, 32'h0000_0001, 4'hf, 0);
  add_row(enc_r(f7_base, 4, 3, f3_sltu, 17), 0, 128, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 17, 0, f3_word), 0, 132, 8, 32'h0000_0000, 4'hf, 0);
  add_row(enc_i(-4, 3, f3_slt, 18, op_reg_imm), 0, 136, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 18, 0, f3_word), 0, 140, 8, 32'h0000_0001, 4'hf, 0);
  add_row(enc_i(-1, 4, f3_sltu, 19, op_reg_imm), 0, 144, 0, 0, 4'h0, 0);
  add_row(enc_s(8, 19, 0, f3_word), 0, 148, 8, 32'h0000_0001, 4'hf, 0);
  // byte and halfword lanes of x10 = 0x380
  add_row(enc_s(0, 10, 0, f3_byte), 0, 152, 0, 32'h8080_8080, 4'h1, 0);
  add_row(enc_s(1, 10, 0, f3_byte), 0, 156, 0, 32'h8080_8080, 4'h2, 0);
  add_row(enc_s(6, 10, 0, f3_byte), 0, 160, 4, 32'h8080_8080, 4'h4, 0);
  add_row(enc_s(11, 10, 0, f3_byte), 0, 164, 8, 32'h8080_8080, 4'h8, 0);
  add_row(enc_s(0, 10, 0, f3_half), 0, 168, 0, 32'h0380_0380, 4'h3, 0);
  add_row(enc_s(14, 10, 0, f3_half), 0, 172, 12, 32'h0380_0380, 4'hc, 0);
  // loads from the word 8a7fc3e1
  add_row(enc_i(1, 0, f3_byte, 20, op_load), lw_data, 176, 0, 0, 4'h0, 0);
  add_row(enc_s(32, 20, 0, f3_word), 0, 180, 32, 32'hffff_ffc3, 4'hf, 0);
  add_row(enc_i(3, 0, f3_byte_u, 21, op_load), lw_data, 184, 0, 0, 4'h0, 0);
  add_row(enc_s(32, 21, 0, f3_word), 0, 188, 32, 32'h0000_008a, 4'hf, 0);
  add_row(enc_i(2, 0, f3_half, 22, op_load), lw_data, 192, 0, 0, 4'h0, 0);
  add_row(enc_s(32, 22, 0, f3_word), 0, 196, 32, 32'hffff_8a7f, 4'hf, 0);
  add_row(enc_i(0, 0, f3_half_u, 23, op_load), lw_data, 200, 0, 0, 4'h0, 0);
  add_row(enc_s(32, 23, 0, f3_word), 0, 204, 32, 32'h0000_c3e1, 4'hf, 0);
  add_row(enc_i(8, 0, f3_word, 24, op_load), lw_data, 208, 8, 0, 4'h0, 0);
  add_row(enc_s(32, 24, 0, f3_word), 0, 212, 32, lw_data, 4'hf, 0);
  // branches, x3 = -5 and x4 = 7
  add_row(enc_b(8, 4, 4, f3_beq), 0, 216, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 3, f3_beq), 0, 224, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 3, f3_bne), 0, 228, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 4, f3_bne), 0, 236, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 3, f3_blt), 0, 240, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 3, 4, f3_blt), 0, 248, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 3, 4, f3_bge), 0, 252, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 3, f3_bge), 0, 260, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 3, 4, f3_bltu), 0, 264, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 3, f3_bltu), 0, 272, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 4, 3, f3_bgeu), 0, 276, 0, 0, 4'h0, 0);
  add_row(enc_b(8, 3, 4, f3_bgeu), 0, 284, 0, 0, 4'h0, 0);
  // jumps, jalr target 401 lands on 400
  add_row(enc_j(12, 25), 0, 288, 0, 0, 4'h0, 0);
  add_row(enc_s(36, 25, 0, f3_word), 0, 300, 36, 32'd292, 4'hf, 0);
  add_row(enc_i(401, 0, f3_add, 26, op_reg_imm), 0, 304, 0, 0, 4'h0, 0);
  add_row(enc_i(0, 26, 3'b000, 27, op_jalr), 0, 308, 0, 0, 4'h0, 0);
  add_row(enc_s(40, 27, 0, f3_word), 0, 400, 40, 32'd312, 4'hf, 0);
  add_row(enc_i(55, 0, f3_add, 0, op_reg_imm), 0, 404, 0, 0, 4'h0, 0);
  add_row(enc_s(44, 0, 0, f3_word), 0, 408, 44, 32'd0, 4'hf, 0);
  add_row(32'h0000_0073, 0, 412, 0, 0, 4'h0, 1);
  add_row(nop_insn, 0, 416, 0, 0, 4'h0, 0);
endtask

// File: rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

  localparam word_t nop_insn     = 32'h0000_0013;
  localparam int    edge_timeout = 4;

  // one program step with the port values expected during it
  typedef struct packed {
    word_t    insn;
    word_t    load_data;
    word_t    pc;
    word_t    addr;
    word_t    store_data;
    byte_en_t store_we;
    logic     halt;
  } row_t;

  logic     clk;
  logic     rst;
  word_t    pc_to_imem;
  word_t    insn_from_imem;
  word_t    addr_to_dmem;
  word_t    load_data_from_dmem;
  word_t    store_data_to_dmem;
  byte_en_t store_we_to_dmem;
  logic     halt;

  row_t rows[$];

  rv_core UUT (
    .clk                 (clk),
    .rst                 (rst),
    .pc_to_imem          (pc_to_imem),
    .insn_from_imem      (insn_from_imem),
    .addr_to_dmem        (addr_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .halt                (halt)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // level 1 waits for a rising edge, level 0 for a falling edge
  task automatic wait_edge(input logic level);
    int n;
    n = 0;
    do begin
      @(clk);
      n++;
    end while (clk !== level && n < edge_timeout);
    if (clk !== level) begin
      stop_with_failure("clock edge did not arrive in time");
    end
  endtask

  task automatic add_row(input word_t insn, input word_t ld, input word_t pc,
                         input word_t addr, input word_t sd, input byte_en_t we,
                         input logic hlt);
    rows.push_back({insn, ld, pc, addr, sd, we, hlt});
  endtask

  // instruction encoders for the program table
  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input funct3_t f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input funct3_t f3, input reg_addr_t rd,
                                  input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                  input opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  `include "rv_core_tb_prog.svh"

  initial begin
    rst                 = 1'b1;
    insn_from_imem      = nop_insn;
    load_data_from_dmem = '0;
    load_program();
    repeat (10) wait_edge(1'b1);
    wait_edge(1'b0);
    rst = 1'b0;
    foreach (rows[i]) begin
      insn_from_imem      = rows[i].insn;
      load_data_from_dmem = rows[i].load_data;
      #2;
      check("pc_to_imem", pc_to_imem, rows[i].pc);
      check("addr_to_dmem", addr_to_dmem, rows[i].addr);
      check("store_data_to_dmem", store_data_to_dmem, rows[i].store_data);
      check("store_we_to_dmem", word_t'(store_we_to_dmem), word_t'(rows[i].store_we));
      check("halt", word_t'(halt), word_t'(rows[i].halt));
      wait_edge(1'b0);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: rv_core.sv
module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output word_t    pc_to_imem,
  input  word_t    insn_from_imem,
  output word_t    addr_to_dmem,
  input  word_t    load_data_from_dmem,
  output word_t    store_data_to_dmem,
  output byte_en_t store_we_to_dmem,
  output logic     halt
);

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t eff_addr;
  word_t link_addr;
  word_t rd_data;
  logic  rd_we;

  rv_decode u_decode (
    .insn (insn_from_imem),
    .ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .rd_data  (rd_data),
    .we       (rd_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // pc lives in the execute unit and goes straight out to fetch
  rv_execute u_execute (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc_to_imem),
    .alu_result (alu_result),
    .eff_addr   (eff_addr),
    .link_addr  (link_addr)
  );

  rv_result u_result (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .eff_addr   (eff_addr),
    .link_addr  (link_addr),
    .rs2_data   (rs2_data),
    .load_data  (load_data_from_dmem),
    .rd_data    (rd_data),
    .rd_we      (rd_we),
    .dmem_addr  (addr_to_dmem),
    .store_data (store_data_to_dmem),
    .store_we   (store_we_to_dmem),
    .halt       (halt)
  );

endmodule

// File: rv_result.sv
module rv_result import rv_pkg::*; (
  input  ctrl_t    ctrl,
  input  word_t    alu_result,
  input  word_t    eff_addr,
  input  word_t    link_addr,
  input  word_t    rs2_data,
  input  word_t    load_data,
  output word_t    rd_data,
  output logic     rd_we,
  output word_t    dmem_addr,
  output word_t    store_data,
  output byte_en_t store_we,
  output logic     halt
);

  logic [1:0] offset;
  logic [7:0] load_byte;
  logic [15:0] load_half;
  word_t      load_value;

  assign offset = eff_addr[1:0];

  // word aligned, and only driven for memory accesses
  assign dmem_addr = (ctrl.is_load || ctrl.is_store) ? {eff_addr[31:2], 2'b00} : '0;

  // stores replicate the data, the enable picks the lane
  always_comb begin
    store_data = '0;
    store_we   = '0;
    if (ctrl.is_store) begin
      case (ctrl.funct3)
        f3_byte: begin
          store_data = {4{rs2_data[7:0]}};
          store_we   = byte_en_t'(4'b0001 << offset);
        end
        f3_half: begin
          store_data = {2{rs2_data[15:0]}};
          store_we   = offset[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          store_data = rs2_data;
          store_we   = 4'b1111;
        end
      endcase
    end
  end

  // lane extraction for loads
  always_comb begin
    case (offset)
      2'd0:    load_byte = load_data[7:0];
      2'd1:    load_byte = load_data[15:8];
      2'd2:    load_byte = load_data[23:16];
      default: load_byte = load_data[31:24];
    endcase
  end

  assign load_half = offset[1] ? load_data[31:16] : load_data[15:0];

  always_comb begin
    case (ctrl.funct3)
      f3_byte:   load_value = {{24{load_byte[7]}}, load_byte};
      f3_half:   load_value = {{16{load_half[15]}}, load_half};
      f3_byte_u: load_value = {24'b0, load_byte};
      f3_half_u: load_value = {16'b0, load_half};
      default:   load_value = load_data;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_alu:  rd_data = alu_result;
      wb_load: rd_data = load_value;
      wb_link: rd_data = link_addr;
      default: rd_data = '0;
    endcase
  end

  assign rd_we = ctrl.wb_sel != wb_none;
  assign halt  = ctrl.is_ecall;

endmodule

// File: rv_execute.sv
module rv_execute import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t pc,
  output word_t alu_result,
  output word_t eff_addr,
  output word_t link_addr
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       taken;
  word_t      pc_target;
  word_t      next_pc;

  assign op_a  = ctrl.use_pc ? pc : rs1_data;
  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << shamt;
      alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {31'b0, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = $signed(op_a) >>> shamt;
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // branch compare always works on the two registers
  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (ctrl.funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // loads, stores and jalr share this adder
  assign eff_addr  = rs1_data + ctrl.imm;
  assign link_addr = pc + 32'd4;
  assign pc_target = pc + ctrl.imm;

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = {eff_addr[31:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
      next_pc = pc_target;
    end else begin
      next_pc = link_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// File: rv_regfile.sv
module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  word_t     rd_data,
  input  logic      we,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  localparam int num_regs = 32;

  word_t regs [num_regs];

  // asynchronous reads, x0 always reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: rv_decode.sv
module rv_decode import rv_pkg::*; (
  input  word_t insn,
  output ctrl_t ctrl
);

  opcode_t    opcode;
  funct3_t    f3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       is_reg;
  logic       f7_alt_ok;
  logic       f7_checked;
  logic       alu_valid;
  logic       use_alt;
  alu_op_e    alu_sel;

  assign opcode = insn[6:0];
  assign f3     = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // alu operation from funct3 and funct7 for both reg-reg and reg-imm
  assign is_reg     = opcode == op_reg_reg;
  assign f7_alt_ok  = (f3 == f3_add && is_reg) || f3 == f3_srl;
  // immediate forms only constrain funct7 for the shifts
  assign f7_checked = is_reg || f3 == f3_sll || f3 == f3_srl;
  assign alu_valid  = !f7_checked || funct7 == f7_base || (f7_alt_ok && funct7 == f7_alt);
  assign use_alt    = f7_alt_ok && funct7 == f7_alt;

  always_comb begin
    case (f3)
      f3_add:  alu_sel = use_alt ? alu_sub : alu_add;
      f3_sll:  alu_sel = alu_sll;
      f3_slt:  alu_sel = alu_slt;
      f3_sltu: alu_sel = alu_sltu;
      f3_xor:  alu_sel = alu_xor;
      f3_srl:  alu_sel = use_alt ? alu_sra : alu_srl;
      f3_or:   alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  end

  always_comb begin
    // defaults describe an instruction that does nothing
    ctrl           = '0;
    ctrl.alu_op    = alu_add;
    ctrl.imm       = imm_i;
    ctrl.rd        = insn[11:7];
    ctrl.rs1       = insn[19:15];
    ctrl.rs2       = insn[24:20];
    ctrl.wb_sel    = wb_none;
    ctrl.funct3    = f3;

    case (opcode)
      op_lui: begin
        ctrl.alu_op  = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.wb_sel  = wb_alu;
      end
      op_auipc: begin
        ctrl.use_imm = 1'b1;
        ctrl.use_pc  = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.wb_sel  = wb_alu;
      end
      op_jal: begin
        ctrl.imm    = imm_j;
        ctrl.wb_sel = wb_link;
        ctrl.is_jal = 1'b1;
      end
      op_jalr: begin
        if (f3 == 3'b000) begin
          ctrl.wb_sel  = wb_link;
          ctrl.is_jalr = 1'b1;
        end
      end
      op_branch: begin
        ctrl.imm       = imm_b;
        // 010 and 011 are not branch conditions
        ctrl.is_branch = f3[2:1] != 2'b01;
      end
      op_load: begin
        if (f3 == f3_byte || f3 == f3_half || f3 == f3_word ||
            f3 == f3_byte_u || f3 == f3_half_u) begin
          ctrl.wb_sel  = wb_load;
          ctrl.is_load = 1'b1;
        end
      end
      op_store: begin
        ctrl.imm      = imm_s;
        ctrl.is_store = f3 == f3_byte || f3 == f3_half || f3 == f3_word;
      end
      op_reg_imm, op_reg_reg: begin
        if (alu_valid) begin
          ctrl.alu_op  = alu_sel;
          ctrl.use_imm = !is_reg;
          ctrl.wb_sel  = wb_alu;
        end
      end
      op_system: begin
        ctrl.is_ecall = insn[31:7] == '0;
      end
      // fence and unknown opcodes keep the defaults and act as a nop
      default: ;
    endcase
  end

endmodule

// File: rv_pkg.sv
package rv_pkg;

  // machine data width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  // major opcodes
  localparam opcode_t op_load     = 7'b00_000_11;
  localparam opcode_t op_store    = 7'b01_000_11;
  localparam opcode_t op_branch   = 7'b11_000_11;
  localparam opcode_t op_jalr     = 7'b11_001_11;
  localparam opcode_t op_misc_mem = 7'b00_011_11;
  localparam opcode_t op_jal      = 7'b11_011_11;
  localparam opcode_t op_reg_imm  = 7'b00_100_11;
  localparam opcode_t op_reg_reg  = 7'b01_100_11;
  localparam opcode_t op_system   = 7'b11_100_11;
  localparam opcode_t op_auipc    = 7'b00_101_11;
  localparam opcode_t op_lui      = 7'b01_101_11;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load and store access widths
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  // alu operations, same codes for register and immediate forms
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_srl  = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // funct7 values, alt selects sub and sra
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // immediate straight through, for lui
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link,
    wb_none
  } wb_sel_e;

  // decoded instruction
  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_imm;
    logic      use_pc;
    word_t     imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    wb_sel_e   wb_sel;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_ecall;
    funct3_t   funct3;
  } ctrl_t;

endpackage
